// File: source/backend_cfg.svh
`ifndef BACKEND_CFG_SVH
`define BACKEND_CFG_SVH

// ##########################################################################
// back end sizing
// ##########################################################################

// data path width in bits
`define BACKEND_XLEN 64

// architectural registers, the last one doubles as stack pointer
`define BACKEND_NREGS 16
`define BACKEND_SP 15

// data RAM depth in 64-bit words, word address is byte address [10:3]
`define BACKEND_RAM_WORDS 256

`endif

// File: source/backend_pkg.sv
`default_nettype none

`include "backend_cfg.svh"

package backend_pkg;

	typedef logic [`BACKEND_XLEN-1:0] word_t;
	typedef logic [$clog2(`BACKEND_NREGS)-1:0] reg_idx_t;

	// what an operand names
	typedef enum logic [2:0] {
		kind_none,
		kind_reg,
		kind_imm,
		kind_mem,
		kind_stack
	} oprd_kind_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_mov
	} alu_op_e;

	typedef enum logic [1:0] {
		op_none,
		op_read,
		op_write
	} mem_op_e;

	// value is the immediate for imm, the displacement for mem
	typedef struct packed {
		oprd_kind_e kind;
		reg_idx_t r;
		word_t value;
	} operand_t;

	typedef struct packed {
		alu_op_e op;
		operand_t dst;
		operand_t src;
	} micro_op_t;

	// execute to memory, data is the ALU result or the store word
	typedef struct packed {
		logic valid;
		mem_op_e mem_op;
		word_t addr;
		word_t data;
		reg_idx_t dst_reg;
		logic dst_we;
		logic sp_we;
		word_t sp_value;
	} exec_out_t;

	typedef struct packed {
		logic valid;
		reg_idx_t dst_reg;
		logic dst_we;
		word_t value;
		logic sp_we;
		word_t sp_value;
	} retire_t;

	// register writes a stage still owes, used for hazard checks
	typedef struct packed {
		logic valid;
		reg_idx_t dst_reg;
		logic dst_we;
		logic sp_we;
	} pend_t;

endpackage

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "backend_cfg.svh"

module reg_file (
	input logic clk,
	input logic rst,
	input backend_pkg::reg_idx_t ra_idx,
	input backend_pkg::reg_idx_t rb_idx,
	output backend_pkg::word_t ra_data,
	output backend_pkg::word_t rb_data,
	input logic w_en,
	input backend_pkg::reg_idx_t w_idx,
	input backend_pkg::word_t w_data,
	input logic sp_en,
	input backend_pkg::word_t sp_data
);

	backend_pkg::word_t regs [`BACKEND_NREGS];

	// combinational reads, a write shows up the cycle after
	assign ra_data = regs[ra_idx];
	assign rb_data = regs[rb_idx];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `BACKEND_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (w_en) begin
				regs[w_idx] <= w_data;
			end
			// stack pointer port comes last so it wins a collision
			if (sp_en) begin
				regs[`BACKEND_SP] <= sp_data;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/exec_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "backend_cfg.svh"

module exec_stage (
	input logic clk,
	input logic rst,
	input logic uop_valid,
	input backend_pkg::micro_op_t uop,
	output logic uop_ready,
	output backend_pkg::reg_idx_t ra_idx,
	output backend_pkg::reg_idx_t rb_idx,
	input backend_pkg::word_t ra_data,
	input backend_pkg::word_t rb_data,
	input logic mem_blocked,
	input backend_pkg::pend_t mem_pend,
	input backend_pkg::pend_t wb_pend,
	output backend_pkg::exec_out_t ex_out,
	output backend_pkg::pend_t ex_pend
);

	logic stack_op;
	logic ra_used;
	logic rb_used;
	logic hazard;
	backend_pkg::word_t alu_a;
	backend_pkg::word_t alu_b;
	backend_pkg::word_t alu_res;
	backend_pkg::exec_out_t nxt;

	// true when stage p will still write register idx
	function automatic logic will_write(input backend_pkg::pend_t p,
			input backend_pkg::reg_idx_t idx);
		return p.valid && ((p.dst_we && p.dst_reg == idx) ||
			(p.sp_we && idx == backend_pkg::reg_idx_t'(`BACKEND_SP)));
	endfunction

	// ######################################################################
	// operand fetch and hazards
	// ######################################################################

	// port a serves the destination, a store base or the stack pointer
	assign stack_op = (uop.dst.kind == backend_pkg::kind_stack) ||
		(uop.src.kind == backend_pkg::kind_stack);
	assign ra_idx = stack_op ? backend_pkg::reg_idx_t'(`BACKEND_SP) : uop.dst.r;
	assign rb_idx = uop.src.r;

	assign ra_used = stack_op || (uop.dst.kind == backend_pkg::kind_reg) ||
		(uop.dst.kind == backend_pkg::kind_mem);
	assign rb_used = (uop.src.kind == backend_pkg::kind_reg) ||
		(uop.src.kind == backend_pkg::kind_mem);

	assign hazard = (ra_used && (will_write(ex_pend, ra_idx) ||
		will_write(mem_pend, ra_idx) || will_write(wb_pend, ra_idx))) ||
		(rb_used && (will_write(ex_pend, rb_idx) ||
		will_write(mem_pend, rb_idx) || will_write(wb_pend, rb_idx)));

	assign uop_ready = !mem_blocked && !hazard;

	// ######################################################################
	// ALU and address generation
	// ######################################################################

	always_comb begin
		alu_a = (uop.dst.kind == backend_pkg::kind_reg) ? ra_data : '0;
		case (uop.src.kind)
			backend_pkg::kind_reg: alu_b = rb_data;
			backend_pkg::kind_imm: alu_b = uop.src.value;
			default: alu_b = '0;
		endcase
		case (uop.op)
			backend_pkg::alu_add: alu_res = alu_a + alu_b;
			backend_pkg::alu_sub: alu_res = alu_a - alu_b;
			backend_pkg::alu_and: alu_res = alu_a & alu_b;
			backend_pkg::alu_or: alu_res = alu_a | alu_b;
			backend_pkg::alu_xor: alu_res = alu_a ^ alu_b;
			default: alu_res = alu_b;
		endcase
	end

	always_comb begin
		nxt = '0;
		nxt.valid = uop_valid && !hazard;
		nxt.data = alu_res;
		nxt.dst_reg = uop.dst.r;
		nxt.dst_we = (uop.dst.kind == backend_pkg::kind_reg);
		// memory operands take priority over stack operands
		if (uop.dst.kind == backend_pkg::kind_mem) begin
			nxt.mem_op = backend_pkg::op_write;
			nxt.addr = ra_data + uop.dst.value;
		end else if (uop.src.kind == backend_pkg::kind_mem) begin
			nxt.mem_op = backend_pkg::op_read;
			nxt.addr = rb_data + uop.src.value;
		end else if (uop.dst.kind == backend_pkg::kind_stack) begin
			// push decrements sp before the write
			nxt.mem_op = backend_pkg::op_write;
			nxt.addr = ra_data - 'd8;
			nxt.sp_we = 1'b1;
			nxt.sp_value = ra_data - 'd8;
		end else if (uop.src.kind == backend_pkg::kind_stack) begin
			// pop reads at sp and then increments it
			nxt.mem_op = backend_pkg::op_read;
			nxt.addr = ra_data;
			nxt.sp_we = 1'b1;
			nxt.sp_value = ra_data + 'd8;
		end
	end

	// output register is frozen while the bus is busy
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_out <= '0;
		end else if (!mem_blocked) begin
			ex_out <= nxt;
		end
	end

	assign ex_pend.valid = ex_out.valid;
	assign ex_pend.dst_reg = ex_out.dst_reg;
	assign ex_pend.dst_we = ex_out.dst_we;
	assign ex_pend.sp_we = ex_out.sp_we;

endmodule

`default_nettype wire

// File: source/mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "backend_cfg.svh"

module mem_stage (
	input logic clk,
	input logic rst,
	input backend_pkg::exec_out_t ex_out,
	output logic mem_blocked,
	output backend_pkg::retire_t wb_in,
	output backend_pkg::pend_t mem_pend,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [`BACKEND_XLEN-1:0] wb_adr,
	output logic [`BACKEND_XLEN-1:0] wb_dat_w,
	input logic [`BACKEND_XLEN-1:0] wb_dat_r,
	input logic wb_ack
);

	typedef enum logic {
		mem_idle,
		mem_waiting
	} state_e;

	state_e state;
	logic take;
	logic start_access;
	backend_pkg::retire_t res;

	// ######################################################################
	// classify the incoming micro-op
	// ######################################################################

	// a new micro-op is only taken while no bus cycle is open
	always_comb begin
		take = (state == mem_idle) && ex_out.valid;
		start_access = take && (ex_out.mem_op != backend_pkg::op_none);
	end

	// execute stage must hold its output until the ack has been seen
	assign mem_blocked = (state == mem_waiting);

	// ######################################################################
	// bus sequencing
	// ######################################################################

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mem_idle;
			res <= '0;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
			wb_adr <= '0;
			wb_dat_w <= '0;
		end else begin
			res.valid <= 1'b0;
			case (state)
				mem_idle: begin
					if (take) begin
						res.dst_reg <= ex_out.dst_reg;
						res.dst_we <= ex_out.dst_we;
						res.sp_we <= ex_out.sp_we;
						res.sp_value <= ex_out.sp_value;
						res.value <= ex_out.data;
						// nothing to fetch, pass straight on
						res.valid <= !start_access;
					end
					if (start_access) begin
						state <= mem_waiting;
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						wb_we <= (ex_out.mem_op == backend_pkg::op_write);
						wb_adr <= ex_out.addr;
						wb_dat_w <= ex_out.data;
					end
				end
				mem_waiting: begin
					if (wb_ack) begin
						state <= mem_idle;
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						wb_we <= 1'b0;
						res.valid <= 1'b1;
						// loads and pops carry the bus word as result
						if (!wb_we) begin
							res.value <= wb_dat_r;
						end
					end
				end
				default: state <= mem_idle;
			endcase
		end
	end

	assign wb_in = res;

	// either the op on the bus or the one just handed on
	assign mem_pend.valid = res.valid || (state == mem_waiting);
	assign mem_pend.dst_reg = res.dst_reg;
	assign mem_pend.dst_we = res.dst_we;
	assign mem_pend.sp_we = res.sp_we;

endmodule

`default_nettype wire

// File: source/writeback_stage.sv
`timescale 1ns/10ps
`default_nettype none

module writeback_stage (
	input logic clk,
	input logic rst,
	input backend_pkg::retire_t wb_in,
	output logic w_en,
	output backend_pkg::reg_idx_t w_idx,
	output backend_pkg::word_t w_data,
	output logic sp_en,
	output backend_pkg::word_t sp_data,
	output backend_pkg::pend_t wb_pend,
	output backend_pkg::retire_t retire
);

	backend_pkg::retire_t cur;

	always_ff @(posedge clk) begin
		if (rst) begin
			cur <= '0;
		end else begin
			cur <= wb_in;
		end
	end

	// ######################################################################
	// register file writes, taken on the edge that ends the retire cycle
	// ######################################################################

	assign w_en = cur.valid && cur.dst_we;
	assign w_idx = cur.dst_reg;
	assign w_data = cur.value;

	assign sp_en = cur.valid && cur.sp_we;
	assign sp_data = cur.sp_value;

	// still owed until the edge, so reads must wait one more cycle
	assign wb_pend.valid = cur.valid;
	assign wb_pend.dst_reg = cur.dst_reg;
	assign wb_pend.dst_we = cur.dst_we;
	assign wb_pend.sp_we = cur.sp_we;

	assign retire = cur;

endmodule

`default_nettype wire

// File: source/data_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "backend_cfg.svh"

module data_ram (
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [`BACKEND_XLEN-1:0] adr,
	input logic [`BACKEND_XLEN-1:0] dat_w,
	output logic [`BACKEND_XLEN-1:0] dat_r,
	output logic ack
);

	logic [`BACKEND_XLEN-1:0] mem [`BACKEND_RAM_WORDS];
	logic [$clog2(`BACKEND_RAM_WORDS)-1:0] word_idx;
	logic req;

	// byte address to word index, low three bits select a byte
	assign word_idx = adr[$clog2(`BACKEND_RAM_WORDS)+2:3];

	// a request still open on the ack cycle is the same one
	assign req = cyc && stb && !ack;

	// power-up contents, unwritten words read as zero
	initial begin
		for (int i = 0; i < `BACKEND_RAM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	// ######################################################################
	// single wait state access
	// ######################################################################

	always_ff @(posedge clk) begin
		if (rst) begin
			ack <= 1'b0;
		end else begin
			ack <= req;
		end
	end

	always_ff @(posedge clk) begin
		if (req && we) begin
			mem[word_idx] <= dat_w;
		end
		if (req) begin
			dat_r <= mem[word_idx];
		end
	end

endmodule

`default_nettype wire

// File: source/backend_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "backend_cfg.svh"

module backend_top (
	input logic clk,
	input logic rst,
	input logic uop_valid,
	input backend_pkg::micro_op_t uop,
	output logic uop_ready,
	output backend_pkg::retire_t retire
);

	backend_pkg::reg_idx_t ra_idx;
	backend_pkg::reg_idx_t rb_idx;
	backend_pkg::word_t ra_data;
	backend_pkg::word_t rb_data;
	backend_pkg::exec_out_t ex_out;
	backend_pkg::retire_t wb_in;
	backend_pkg::pend_t ex_pend;
	backend_pkg::pend_t mem_pend;
	backend_pkg::pend_t wb_pend;
	logic mem_blocked;

	// register file write side
	logic w_en;
	backend_pkg::reg_idx_t w_idx;
	backend_pkg::word_t w_data;
	logic sp_en;
	backend_pkg::word_t sp_data;

	// wishbone between memory stage and RAM
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic wb_ack;
	logic [`BACKEND_XLEN-1:0] wb_adr;
	logic [`BACKEND_XLEN-1:0] wb_dat_w;
	logic [`BACKEND_XLEN-1:0] wb_dat_r;

	exec_stage u_exec (
		.clk(clk), .rst(rst), .uop_valid(uop_valid), .uop(uop), .uop_ready(uop_ready),
		.ra_idx(ra_idx), .rb_idx(rb_idx), .ra_data(ra_data), .rb_data(rb_data),
		.mem_blocked(mem_blocked), .mem_pend(mem_pend), .wb_pend(wb_pend),
		.ex_out(ex_out), .ex_pend(ex_pend)
	);

	mem_stage u_mem (
		.clk(clk), .rst(rst), .ex_out(ex_out), .mem_blocked(mem_blocked),
		.wb_in(wb_in), .mem_pend(mem_pend), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
		.wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack)
	);

	writeback_stage u_wb (
		.clk(clk), .rst(rst), .wb_in(wb_in), .w_en(w_en), .w_idx(w_idx),
		.w_data(w_data), .sp_en(sp_en), .sp_data(sp_data), .wb_pend(wb_pend),
		.retire(retire)
	);

	reg_file u_regs (
		.clk(clk), .rst(rst), .ra_idx(ra_idx), .rb_idx(rb_idx), .ra_data(ra_data),
		.rb_data(rb_data), .w_en(w_en), .w_idx(w_idx), .w_data(w_data),
		.sp_en(sp_en), .sp_data(sp_data)
	);

	data_ram u_ram (
		.clk(clk), .rst(rst), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
		.dat_w(wb_dat_w), .dat_r(wb_dat_r), .ack(wb_ack)
	);

endmodule

`default_nettype wire

// File: testbench/backend_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "backend_cfg.svh"

module backend_tb;

	// micro-ops per test in run order
	localparam int uop_total = 16 + 40 + 17 + 12 + 12 + 200;
	localparam int cycle_limit = uop_total * 6 + 100;

	logic clk;
	logic rst;
	logic uop_valid;
	backend_pkg::micro_op_t uop;
	logic uop_ready;
	backend_pkg::retire_t retire;

	backend_pkg::word_t model_regs [`BACKEND_NREGS];
	backend_pkg::word_t model_ram [`BACKEND_RAM_WORDS];
	backend_pkg::retire_t expected [$];

	string test_name;
	int error_count;
	int test_err_start;
	int tests_ok;
	int tests_bad;
	int retired;
	int blocked_cycles;
	int cycles;

	backend_top dut (
		.clk(clk), .rst(rst), .uop_valid(uop_valid), .uop(uop),
		.uop_ready(uop_ready), .retire(retire)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ##########################################################################
	// stimulus helpers
	// ##########################################################################

	function automatic backend_pkg::word_t rand_word();
		return {$urandom, $urandom};
	endfunction

	function automatic backend_pkg::micro_op_t make_uop(input backend_pkg::alu_op_e op,
			input backend_pkg::oprd_kind_e dk, input int dr, input backend_pkg::word_t dv,
			input backend_pkg::oprd_kind_e sk, input int sr, input backend_pkg::word_t sv);
		backend_pkg::micro_op_t u;
		u.op = op;
		u.dst.kind = dk;
		u.dst.r = backend_pkg::reg_idx_t'(dr);
		u.dst.value = dv;
		u.src.kind = sk;
		u.src.r = backend_pkg::reg_idx_t'(sr);
		u.src.value = sv;
		return u;
	endfunction

	// any legal operand combination with random registers and displacements
	function automatic backend_pkg::micro_op_t random_uop();
		backend_pkg::alu_op_e op;
		backend_pkg::oprd_kind_e sk;
		backend_pkg::word_t disp;
		int dr;
		int sr;
		op = backend_pkg::alu_op_e'($urandom_range(0, 5));
		dr = $urandom_range(0, 15);
		sr = $urandom_range(0, 15);
		disp = 64'($urandom_range(0, 255));
		case ($urandom_range(0, 3))
			0: sk = backend_pkg::kind_none;
			1: sk = backend_pkg::kind_imm;
			default: sk = backend_pkg::kind_reg;
		endcase
		case ($urandom_range(0, 6))
			0, 1: return make_uop(op, backend_pkg::kind_reg, dr, '0, sk, sr, rand_word());
			2: return make_uop(op, backend_pkg::kind_mem, dr, disp, sk, sr, rand_word());
			3: return make_uop(op, backend_pkg::kind_reg, dr, '0, backend_pkg::kind_mem, sr, disp);
			4: return make_uop(op, backend_pkg::kind_stack, 0, '0, sk, sr, rand_word());
			5: return make_uop(op, backend_pkg::kind_reg, dr, '0,
				backend_pkg::kind_stack, 0, '0);
			default: return make_uop(op, backend_pkg::kind_none, 0, '0, sk, sr, rand_word());
		endcase
	endfunction

	// ##########################################################################
	// reference model
	// ##########################################################################

	function automatic void model_step(input backend_pkg::micro_op_t u);
		backend_pkg::retire_t exp;
		backend_pkg::word_t a;
		backend_pkg::word_t b;
		backend_pkg::word_t addr;
		exp = '0;
		exp.valid = 1'b1;
		a = (u.dst.kind == backend_pkg::kind_reg) ? model_regs[u.dst.r] : '0;
		case (u.src.kind)
			backend_pkg::kind_reg: b = model_regs[u.src.r];
			backend_pkg::kind_imm: b = u.src.value;
			default: b = '0;
		endcase
		case (u.op)
			backend_pkg::alu_add: exp.value = a + b;
			backend_pkg::alu_sub: exp.value = a - b;
			backend_pkg::alu_and: exp.value = a & b;
			backend_pkg::alu_or: exp.value = a | b;
			backend_pkg::alu_xor: exp.value = a ^ b;
			default: exp.value = b;
		endcase
		exp.dst_reg = u.dst.r;
		exp.dst_we = (u.dst.kind == backend_pkg::kind_reg);
		// word address is byte address bits [10:3]
		if (u.dst.kind == backend_pkg::kind_mem) begin
			addr = model_regs[u.dst.r] + u.dst.value;
			model_ram[addr[10:3]] = exp.value;
		end else if (u.src.kind == backend_pkg::kind_mem) begin
			addr = model_regs[u.src.r] + u.src.value;
			exp.value = model_ram[addr[10:3]];
		end else if (u.dst.kind == backend_pkg::kind_stack) begin
			exp.sp_we = 1'b1;
			exp.sp_value = model_regs[`BACKEND_SP] - 64'd8;
			model_ram[exp.sp_value[10:3]] = exp.value;
		end else if (u.src.kind == backend_pkg::kind_stack) begin
			addr = model_regs[`BACKEND_SP];
			exp.sp_we = 1'b1;
			exp.sp_value = addr + 64'd8;
			exp.value = model_ram[addr[10:3]];
		end
		// stack pointer update lands last
		if (exp.dst_we) begin
			model_regs[exp.dst_reg] = exp.value;
		end
		if (exp.sp_we) begin
			model_regs[`BACKEND_SP] = exp.sp_value;
		end
		expected.push_back(exp);
	endfunction

	// called 1 ns after a rising edge and returns at the same phase
	task automatic issue(input backend_pkg::micro_op_t u);
		uop = u;
		uop_valid = 1'b1;
		@(negedge clk);
		while (!uop_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		model_step(u);
		#1;
		uop_valid = 1'b0;
	endtask

	// ##########################################################################
	// checking and reporting
	// ##########################################################################

	task automatic report_mismatch(input string field, input backend_pkg::word_t e,
			input backend_pkg::word_t a);
		$display("Fail %s: %s expected %h actual %h", test_name, field, e, a);
		error_count++;
	endtask

	task automatic report_error(input string msg);
		$display("%s: %s", test_name, msg);
		error_count++;
	endtask

	task automatic check_retire(input backend_pkg::retire_t exp);
		retired++;
		if (retire.value !== exp.value) report_mismatch("value", exp.value, retire.value);
		if (retire.dst_we !== exp.dst_we) report_mismatch("dst_we", 64'(exp.dst_we),
			64'(retire.dst_we));
		if (exp.dst_we && retire.dst_reg !== exp.dst_reg) report_mismatch("dst_reg",
			64'(exp.dst_reg), 64'(retire.dst_reg));
		if (retire.sp_we !== exp.sp_we) report_mismatch("sp_we", 64'(exp.sp_we),
			64'(retire.sp_we));
		if (exp.sp_we && retire.sp_value !== exp.sp_value) report_mismatch("sp_value",
			exp.sp_value, retire.sp_value);
	endtask

	// retire port and bus watch sampled mid cycle
	always @(negedge clk) begin
		if (!rst && retire.valid) begin
			if (expected.size() == 0) begin
				report_error("a micro-op retired while none was outstanding");
			end else begin
				check_retire(expected.pop_front());
			end
		end
		if (!rst && dut.wb_cyc) begin
			if (uop_ready) begin
				report_error("uop_ready was high while a bus cycle was open");
			end else begin
				blocked_cycles++;
			end
		end
	end

	task automatic start_test(input string name);
		test_name = name;
		test_err_start = error_count;
	endtask

	task automatic finish_test();
		int errs;
		while (expected.size() != 0) begin
			@(posedge clk);
		end
		@(posedge clk);
		#1;
		errs = error_count - test_err_start;
		if (errs == 0) begin
			$display("%s: ok", test_name);
			tests_ok++;
		end else begin
			$display("%s: %0d errors", test_name, errs);
			tests_bad++;
		end
	endtask

	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("run stopped after %0d cycles, %0d micro-ops never retired",
			cycles, expected.size());
		$display("Test failed");
		$finish;
	end

	// ##########################################################################
	// test sequence
	// ##########################################################################

	initial begin
		int blocked_start;
		backend_pkg::word_t base;
		void'($urandom(1));
		rst = 1'b1;
		uop_valid = 1'b0;
		uop = '0;
		error_count = 0;
		tests_ok = 0;
		tests_bad = 0;
		retired = 0;
		blocked_cycles = 0;
		test_name = "reset";
		for (int i = 0; i < `BACKEND_NREGS; i++) begin
			model_regs[i] = '0;
		end
		for (int i = 0; i < `BACKEND_RAM_WORDS; i++) begin
			model_ram[i] = '0;
		end
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		start_test("reset_and_mov");
		repeat (4) begin
			@(negedge clk);
			if (!uop_ready) report_error("uop_ready low after reset");
			if (retire.valid) report_error("retire valid with nothing issued");
			if (dut.wb_cyc || dut.wb_stb || dut.wb_ack) report_error("bus active after reset");
		end
		@(posedge clk);
		#1;
		for (int i = 0; i < `BACKEND_NREGS - 1; i++) begin
			issue(make_uop(backend_pkg::alu_mov, backend_pkg::kind_reg, i, '0,
				backend_pkg::kind_imm, 0, rand_word()));
		end
		// stack starts at the top of the RAM
		issue(make_uop(backend_pkg::alu_mov, backend_pkg::kind_reg, `BACKEND_SP, '0,
			backend_pkg::kind_imm, 0, 64'h800));
		finish_test();

		start_test("alu_reg_reg");
		for (int k = 0; k < 20; k++) begin
			int src;
			int dst;
			src = $urandom_range(0, 14);
			dst = $urandom_range(0, 14);
			issue(make_uop(backend_pkg::alu_mov, backend_pkg::kind_reg, src, '0,
				backend_pkg::kind_imm, 0, rand_word()));
			issue(make_uop(backend_pkg::alu_op_e'(k / 4), backend_pkg::kind_reg, dst, '0,
				backend_pkg::kind_reg, src, '0));
		end
		finish_test();

		start_test("store_load");
		for (int k = 0; k < 4; k++) begin
			base = 64'($urandom_range(0, 31)) * 64'd8;
			issue(make_uop(backend_pkg::alu_mov, backend_pkg::kind_reg, 1, '0,
				backend_pkg::kind_imm, 0, base));
			issue(make_uop(backend_pkg::alu_mov, backend_pkg::kind_mem, 1, 64'(8 * k),
				backend_pkg::kind_imm, 0, rand_word()));
			issue(make_uop(backend_pkg::alu_mov, backend_pkg::kind_reg, 2, '0,
				backend_pkg::kind_mem, 1, 64'(8 * k)));
		end
		// nothing has been stored from 0x600 up
		issue(make_uop(backend_pkg::alu_mov, backend_pkg::kind_reg, 3, '0,
			backend_pkg::kind_imm, 0, 64'h600));
		for (int k = 0; k < 4; k++) begin
			issue(make_uop(backend_pkg::alu_mov, backend_pkg::kind_reg, 2, '0,
				backend_pkg::kind_mem, 3, 64'(8 * k)));
		end
		finish_test();

		start_test("push_pop");
		for (int k = 0; k < 4; k++) begin
			issue(make_uop(backend_pkg::alu_mov, backend_pkg::kind_reg, 4, '0,
				backend_pkg::kind_imm, 0, rand_word()));
			issue(make_uop(backend_pkg::alu_mov, backend_pkg::kind_stack, 0, '0,
				backend_pkg::kind_reg, 4, '0));
		end
		for (int k = 0; k < 4; k++) begin
			issue(make_uop(backend_pkg::alu_mov, backend_pkg::kind_reg, 5 + k, '0,
				backend_pkg::kind_stack, 0, '0));
		end
		finish_test();

		start_test("dependent_chain");
		blocked_start = blocked_cycles;
		issue(make_uop(backend_pkg::alu_mov, backend_pkg::kind_reg, 9, '0,
			backend_pkg::kind_imm, 0, 64'h100));
		issue(make_uop(backend_pkg::alu_mov, backend_pkg::kind_reg, 11, '0,
			backend_pkg::kind_imm, 0, rand_word()));
		issue(make_uop(backend_pkg::alu_mov, backend_pkg::kind_mem, 9, '0,
			backend_pkg::kind_imm, 0, rand_word()));
		// each store feeds the next load
		for (int k = 0; k < 3; k++) begin
			issue(make_uop(backend_pkg::alu_mov, backend_pkg::kind_reg, 10, '0,
				backend_pkg::kind_mem, 9, 64'(8 * k)));
			issue(make_uop(backend_pkg::alu_add, backend_pkg::kind_reg, 10, '0,
				backend_pkg::kind_reg, 11, '0));
			issue(make_uop(backend_pkg::alu_mov, backend_pkg::kind_mem, 9, 64'(8 * k + 8),
				backend_pkg::kind_reg, 10, '0));
		end
		if (blocked_cycles == blocked_start) begin
			report_error("uop_ready never dropped during a bus cycle");
		end
		finish_test();

		start_test("random_mix");
		for (int k = 0; k < 200; k++) begin
			issue(random_uop());
		end
		finish_test();

		repeat (8) @(posedge clk);
		$display("%0d tests ok, %0d tests failed, %0d micro-ops retired, %0d errors",
			tests_ok, tests_bad, retired, error_count);
		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+source
source/backend_pkg.sv
source/reg_file.sv
source/exec_stage.sv
source/mem_stage.sv
source/writeback_stage.sv
source/data_ram.sv
source/backend_top.sv
testbench/backend_tb.sv

// File: Makefile
VERILATOR   ?= verilator
TOP         := backend_tb
FILELIST    := sim.f
OBJ_DIR     := obj_dir
BUILD_FLAGS := --binary --timing -j 0 -Mdir $(OBJ_DIR)
LINT_FLAGS  := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the status of the last grep decides pass or fail
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
